//--- Makefile
# Verilator build and run of the scatter-gather DMA testbench

VERILATOR ?= verilator
TOP       ?= tb_sg_dma
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- logic/sg_bus_pkg.sv
// wishbone side widths and types: data word, word address, buffer length
package sg_bus_pkg;

   localparam int SG_DW = 64;             // bus data width
   localparam int SG_AW = 29;             // byte address bits 31..3
   localparam int SG_LW = 16;             // length field width

   // one 64 bit beat as returned by the slave
   typedef logic [SG_DW-1:0] sg_data_t;

   // word address, byte address with the three zero bits removed
   // used for command, descriptor and buffer pointers alike
   typedef logic [SG_AW-1:0] sg_waddr_t;

   // buffer length counted in 64 bit words
   typedef logic [SG_LW-1:0] sg_len_t;

endpackage

//--- logic/sg_credit_fifo.sv
// sg_credit_fifo: show-ahead circular buffer returning one credit per pop
`timescale 1ns/1ps

module sg_credit_fifo
   import sg_desc_pkg::*;
#(
   parameter int FIFO_DEPTH = 8                // entries, 2 or more
) (
   input  logic     wb_clk_i,
   input  logic     wb_rst_i,
   input  logic     push_i,                    // never on a full fifo, credits see to it
   input  sg_word_t push_word_i,
   input  logic     pop_i,
   output sg_word_t head_o,                    // oldest entry
   output logic     empty_o,
   output logic     credit_o                   // back to the walker
);

   localparam int PW = $clog2(FIFO_DEPTH);
   localparam int CW = $clog2(FIFO_DEPTH + 1);

   sg_word_t      mem [FIFO_DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [CW-1:0] count;                       // occupancy
   logic          do_pop;

   // wrap for any depth, not only powers of two
   function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
      if (ptr == PW'(FIFO_DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign do_pop   = pop_i & ~empty_o;
   assign empty_o  = (count == '0);
   assign head_o   = mem[rd_ptr];              // visible the cycle after push
   assign credit_o = do_pop;

   always_ff @(posedge wb_clk_i) begin
      if (push_i)
         mem[wr_ptr] <= push_word_i;
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i)
            wr_ptr <= ptr_inc(wr_ptr);
         if (do_pop)
            rd_ptr <= ptr_inc(rd_ptr);
         case ({push_i, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                         // both or neither, unchanged
         endcase
      end
   end

endmodule

//--- logic/sg_desc_pkg.sv
// descriptor field positions, walker state encoding and the stream word type
package sg_desc_pkg;

   // descriptor is two beats
   //  beat 0  [31:3]  buffer word address
   //          [63:32] high half, length at DESC_LEN_LSB, last flag at DESC_LAST_BIT
   //  beat 1  [63:35] next descriptor word address
   localparam int DESC_HI_LSB   = 32;     // start of the high half
   localparam int DESC_LEN_LSB  = 0;      // length lsb within high half
   localparam int DESC_LAST_BIT = 20;     // last flag within high half

   typedef enum logic [2:0] {
      ST_IDLE  = 3'd0,                    // waiting for a command
      ST_DESC0 = 3'd1,                    // fetch beat 0, addr/len/last
      ST_DESC1 = 3'd2,                    // fetch beat 1, next pointer
      ST_BUF   = 3'd3,                    // buffer data beats
      ST_NEXT  = 3'd4,                    // end of buffer, follow or finish
      ST_PANIC = 3'd5                     // bus error seen
   } sg_state_e;

   // item carried from walker through fifo to the stream port
   typedef struct packed {
      logic                last;          // final word of the chain
      sg_bus_pkg::sg_data_t data;
   } sg_word_t;

endpackage

//--- logic/sg_dma_top.sv
// sg_dma_top: scatter-gather read dma, walker to credit fifo to stream port
`timescale 1ns/1ps

module sg_dma_top
   import sg_bus_pkg::*, sg_desc_pkg::*;
#(
   parameter int FIFO_DEPTH = 8                // fifo entries and walker credits
) (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,

   input  logic        cmd_valid_i,
   input  sg_waddr_t   cmd_addr_i,
   output logic        cmd_ready_o,

   output logic        wbm_cyc_o,
   output logic        wbm_stb_o,
   output logic [31:0] wbm_adr_o,
   input  sg_data_t    wbm_dat_i,
   input  logic        wbm_ack_i,
   input  logic        wbm_err_i,

   output logic        st_valid_o,
   output sg_data_t    st_data_o,
   output logic        st_last_o,
   input  logic        st_ready_i,

   output logic        done_o,
   output logic        error_o
);

   logic     push;                             // walker to fifo
   sg_word_t push_word;
   logic     credit;                           // fifo to walker
   sg_word_t head;                             // fifo to stream stage
   logic     empty;
   logic     pop;

   sg_walker #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_sg_walker (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_addr_i  (cmd_addr_i),
      .cmd_ready_o (cmd_ready_o),
      .wbm_cyc_o   (wbm_cyc_o),
      .wbm_stb_o   (wbm_stb_o),
      .wbm_adr_o   (wbm_adr_o),
      .wbm_dat_i   (wbm_dat_i),
      .wbm_ack_i   (wbm_ack_i),
      .wbm_err_i   (wbm_err_i),
      .credit_i    (credit),
      .push_o      (push),
      .push_word_o (push_word),
      .done_o      (done_o),
      .error_o     (error_o)
   );

   sg_credit_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_sg_credit_fifo (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .push_i      (push),
      .push_word_i (push_word),
      .pop_i       (pop),
      .head_o      (head),
      .empty_o     (empty),
      .credit_o    (credit)
   );

   sg_stream_out u_sg_stream_out (
      .head_i     (head),
      .empty_i    (empty),
      .pop_o      (pop),
      .st_valid_o (st_valid_o),
      .st_data_o  (st_data_o),
      .st_last_o  (st_last_o),
      .st_ready_i (st_ready_i)
   );

endmodule

//--- logic/sg_stream_out.sv
// sg_stream_out: valid/ready stream stage draining the buffer fifo
`timescale 1ns/1ps

module sg_stream_out
   import sg_bus_pkg::*, sg_desc_pkg::*;
(
   input  sg_word_t head_i,                    // fifo head, show-ahead
   input  logic     empty_i,
   output logic     pop_o,                     // word taken by the sink

   output logic     st_valid_o,
   output sg_data_t st_data_o,
   output logic     st_last_o,                 // end of chain marker
   input  logic     st_ready_i
);

   // head only moves on pop, so data and last hold while stalled
   assign st_valid_o = ~empty_i;
   assign st_data_o  = head_i.data;
   assign st_last_o  = head_i.last;

   // handshake completes, advance the fifo
   assign pop_o = st_valid_o & st_ready_i;

endmodule

//--- logic/sg_walker.sv
// sg_walker: descriptor chain walker, wishbone read master and credit counter
`timescale 1ns/1ps

module sg_walker
   import sg_bus_pkg::*, sg_desc_pkg::*;
#(
   parameter int FIFO_DEPTH = 8                // credits available at reset
) (
   input  logic      wb_clk_i,
   input  logic      wb_rst_i,

   input  logic      cmd_valid_i,              // command handshake
   input  sg_waddr_t cmd_addr_i,               // first descriptor
   output logic      cmd_ready_o,

   output logic      wbm_cyc_o,                // classic single reads
   output logic      wbm_stb_o,
   output logic [31:0] wbm_adr_o,
   input  sg_data_t  wbm_dat_i,
   input  logic      wbm_ack_i,
   input  logic      wbm_err_i,

   input  logic      credit_i,                 // one per fifo pop
   output logic      push_o,                   // one per data ack
   output sg_word_t  push_word_o,

   output logic      done_o,                   // chain fully fetched
   output logic      error_o                   // sticky until next command
);

   localparam int CW = $clog2(FIFO_DEPTH + 1);

   sg_state_e state;
   logic      bus_req;                         // cyc and stb together
   logic      error_q;
   logic [CW-1:0] credit_cnt;
   logic [CW-1:0] credit_cnt_n;
   logic      have_credit;

   sg_waddr_t adr_q;                           // current bus word address
   sg_waddr_t buf_addr;                        // from beat 0
   sg_len_t   buf_len;                         // words still to read
   logic      last_q;                          // last descriptor flag
   sg_waddr_t next_q;                          // from beat 1

   logic      cmd_accept;
   logic      beat_ack;
   logic      beat_err;
   logic      final_beat;                      // ack on the last word of a buffer

   assign cmd_ready_o = (state == ST_IDLE);
   assign cmd_accept  = cmd_valid_i & cmd_ready_o;
   assign beat_ack    = bus_req & wbm_ack_i;
   assign beat_err    = bus_req & wbm_err_i;
   assign final_beat  = (buf_len == sg_len_t'(1));

   assign wbm_cyc_o = bus_req;
   assign wbm_stb_o = bus_req;
   assign wbm_adr_o = {adr_q, 3'b000};         // word to byte address

   assign push_o           = (state == ST_BUF) & beat_ack;   // pushed with its ack
   assign push_word_o.data = wbm_dat_i;
   assign push_word_o.last = last_q & final_beat;

   assign done_o  = (state == ST_NEXT) & last_q;
   assign error_o = error_q;

   // credits spent per push, returned per pop, both may land together
   // the count runs across commands since the fifo can still hold a tail
   always_comb begin
      credit_cnt_n = credit_cnt;
      if (push_o && !credit_i)
         credit_cnt_n = credit_cnt - 1'b1;
      else if (credit_i && !push_o && credit_cnt != CW'(FIFO_DEPTH))
         credit_cnt_n = credit_cnt + 1'b1;     // saturates at depth
   end

   assign have_credit = (credit_cnt_n != '0);

   // control state
   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state      <= ST_IDLE;
         bus_req    <= 1'b0;
         error_q    <= 1'b0;
         credit_cnt <= CW'(FIFO_DEPTH);
      end else begin
         credit_cnt <= credit_cnt_n;
         case (state)
            ST_IDLE: begin
               if (cmd_accept) begin
                  bus_req <= 1'b1;             // cyc one cycle after accept
                  error_q <= 1'b0;
                  state   <= ST_DESC0;
               end
            end
            ST_DESC0: begin
               if (beat_err) begin
                  bus_req <= 1'b0;
                  state   <= ST_PANIC;
               end else if (beat_ack) begin
                  state <= ST_DESC1;           // stb stays up for beat 1
               end
            end
            ST_DESC1: begin
               if (beat_err) begin
                  bus_req <= 1'b0;
                  state   <= ST_PANIC;
               end else if (beat_ack) begin
                  if (buf_len == '0) begin     // empty buffer, skip data
                     bus_req <= 1'b0;
                     state   <= ST_NEXT;
                  end else begin
                     bus_req <= have_credit;
                     state   <= ST_BUF;
                  end
               end
            end
            ST_BUF: begin
               if (!bus_req) begin
                  bus_req <= have_credit;      // resume once a credit is back
               end else if (beat_err) begin
                  bus_req <= 1'b0;
                  state   <= ST_PANIC;
               end else if (beat_ack) begin
                  if (final_beat) begin
                     bus_req <= 1'b0;
                     state   <= ST_NEXT;
                  end else begin
                     bus_req <= have_credit;   // drop cyc when out of credits
                  end
               end
            end
            ST_NEXT: begin
               if (last_q) begin
                  state <= ST_IDLE;            // done_o this cycle
               end else begin
                  bus_req <= 1'b1;
                  state   <= ST_DESC0;
               end
            end
            ST_PANIC: begin
               error_q <= 1'b1;
               state   <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // descriptor fields and bus address
   always_ff @(posedge wb_clk_i) begin
      case (state)
         ST_IDLE: begin
            if (cmd_accept)
               adr_q <= cmd_addr_i;
         end
         ST_DESC0: begin
            if (beat_ack) begin
               buf_addr <= wbm_dat_i[31:3];
               buf_len  <= wbm_dat_i[DESC_HI_LSB + DESC_LEN_LSB +: $bits(sg_len_t)];
               last_q   <= wbm_dat_i[DESC_HI_LSB + DESC_LAST_BIT];
               adr_q    <= adr_q + 1'b1;       // beat 1 follows
            end
         end
         ST_DESC1: begin
            if (beat_ack) begin
               next_q <= wbm_dat_i[63:35];
               adr_q  <= buf_addr;
            end
         end
         ST_BUF: begin
            if (beat_ack) begin
               adr_q   <= adr_q + 1'b1;
               buf_len <= buf_len - 1'b1;
            end
         end
         ST_NEXT: begin
            if (!last_q)
               adr_q <= next_q;                // follow the chain
         end
         default: ;
      endcase
   end

endmodule

//--- sim.f
logic/sg_bus_pkg.sv
logic/sg_desc_pkg.sv
logic/sg_walker.sv
logic/sg_credit_fifo.sv
logic/sg_stream_out.sv
logic/sg_dma_top.sv
testbench/sg_wb_mem.sv
testbench/sg_dma_asserts.sv
testbench/tb_sg_dma.sv

//--- testbench/sg_dma_asserts.sv
// wishbone handshake, bus state and credit checks bound into the walker
`timescale 1ns/1ps

module sg_dma_asserts
   import sg_desc_pkg::*;
(
   input logic        wb_clk_i,
   input logic        wb_rst_i,
   input logic        cyc_i,
   input logic        stb_i,
   input logic [31:0] adr_i,
   input logic        ack_i,
   input logic        err_i,
   input logic        push_i,
   input logic        credit_zero_i,           // walker credit count at zero
   input sg_state_e   state_i                  // walker fsm state
);

   // every push spends a credit, so one has to be held
   a_push_needs_credit: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      push_i |-> !credit_zero_i)
      else $error("push issued while the credit count was zero");

   // strobe only inside a cycle and only while fetching
   a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      stb_i |-> (cyc_i && (state_i == ST_DESC0 || state_i == ST_DESC1 ||
                           state_i == ST_BUF)))
      else $error("stb high without cyc or outside a fetch state");

   // request and address hold until the slave answers
   a_req_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (cyc_i && stb_i && !ack_i && !err_i) |=> (cyc_i && stb_i && $stable(adr_i)))
      else $error("cyc, stb or address changed before ack or err");

endmodule

bind sg_walker sg_dma_asserts u_sg_dma_asserts (
   .wb_clk_i      (wb_clk_i),
   .wb_rst_i      (wb_rst_i),
   .cyc_i         (wbm_cyc_o),
   .stb_i         (wbm_stb_o),
   .adr_i         (wbm_adr_o),
   .ack_i         (wbm_ack_i),
   .err_i         (wbm_err_i),
   .push_i        (push_o),
   .credit_zero_i (credit_cnt == '0),
   .state_i       (state)
);

//--- testbench/sg_wb_mem.sv
// sg_wb_mem: wishbone classic slave memory with per beat ack delay and an error trap
`timescale 1ns/1ps

module sg_wb_mem
   import sg_bus_pkg::*;
#(
   parameter int        MEM_AW     = 12,       // word index bits
   parameter sg_waddr_t TRAP_WADDR = 29'h7f0   // this word answers with err
) (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic [31:0] adr_i,
   output sg_data_t    dat_o,
   output logic        ack_o,
   output logic        err_o,
   input  logic [1:0]  delay_i                 // wait cycles before the answer
);

   sg_data_t   mem [2**MEM_AW];                // loaded by the testbench
   logic [1:0] wait_cnt;
   sg_waddr_t  waddr;
   logic       req;

   assign waddr = adr_i[31:3];
   // a held strobe right after an answer is the next beat, not this one
   assign req   = cyc_i & stb_i & ~ack_o & ~err_o;

   // every word distinct, so a wrong address shows up in the data
   initial begin
      for (int i = 0; i < 2**MEM_AW; i++)
         mem[i] = {~32'(i), 32'(i) ^ 32'h5a5a_0000};
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ack_o    <= 1'b0;
         err_o    <= 1'b0;
         wait_cnt <= '0;
         dat_o    <= '0;
      end else begin
         ack_o <= 1'b0;                        // single cycle answers
         err_o <= 1'b0;
         if (req) begin
            if (wait_cnt >= delay_i) begin
               wait_cnt <= '0;
               if (waddr == TRAP_WADDR) begin
                  err_o <= 1'b1;               // trap word, bus error
               end else begin
                  ack_o <= 1'b1;
                  dat_o <= mem[waddr[MEM_AW-1:0]];
               end
            end else begin
               wait_cnt <= wait_cnt + 1'b1;
            end
         end else begin
            wait_cnt <= '0;
         end
      end
   end

endmodule

//--- testbench/tb_sg_dma.sv
// tb_sg_dma: random descriptor chains, reference word queue, stream and status checks
`timescale 1ns/1ps

module tb_sg_dma
   import sg_bus_pkg::*, sg_desc_pkg::*;
();

   localparam int        FIFO_DEPTH = 8;
   localparam int        N_CMD      = 10;
   localparam int        ERR_CMD    = 4;       // this chain runs into the trap
   localparam int        TIMEOUT    = 4000;    // cycles allowed per wait
   localparam sg_waddr_t TRAP_WADDR = 29'h7f0;
   localparam sg_waddr_t BUF_BASE   = 29'h800; // buffers above, descriptors below

   logic        wb_clk_i;
   logic        wb_rst_i;
   logic        cmd_valid_i;
   sg_waddr_t   cmd_addr_i;
   logic        cmd_ready_o;
   logic        wbm_cyc_o;
   logic        wbm_stb_o;
   logic [31:0] wbm_adr_o;
   sg_data_t    wbm_dat_i;
   logic        wbm_ack_i;
   logic        wbm_err_i;
   logic        st_valid_o;
   sg_data_t    st_data_o;
   logic        st_last_o;
   logic        st_ready_i;
   logic        done_o;
   logic        error_o;
   logic [1:0]  ack_delay;

   logic [31:0] stim_seed;                     // chains and data
   logic [31:0] bus_seed;                      // ready and ack delay noise
   sg_word_t    expected_q [$];
   int          slot;                          // next free 16 word slot

   sg_dma_top #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_sg_dma_top (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_addr_i  (cmd_addr_i),
      .cmd_ready_o (cmd_ready_o),
      .wbm_cyc_o   (wbm_cyc_o),
      .wbm_stb_o   (wbm_stb_o),
      .wbm_adr_o   (wbm_adr_o),
      .wbm_dat_i   (wbm_dat_i),
      .wbm_ack_i   (wbm_ack_i),
      .wbm_err_i   (wbm_err_i),
      .st_valid_o  (st_valid_o),
      .st_data_o   (st_data_o),
      .st_last_o   (st_last_o),
      .st_ready_i  (st_ready_i),
      .done_o      (done_o),
      .error_o     (error_o)
   );

   sg_wb_mem #(
      .TRAP_WADDR (TRAP_WADDR)
   ) u_sg_wb_mem (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .cyc_i    (wbm_cyc_o),
      .stb_i    (wbm_stb_o),
      .adr_i    (wbm_adr_o),
      .dat_o    (wbm_dat_i),
      .ack_o    (wbm_ack_i),
      .err_o    (wbm_err_i),
      .delay_i  (ack_delay)
   );

   initial begin
      wb_clk_i = 1'b0;
      forever #20 wb_clk_i = ~wb_clk_i;        // 40 ns period
   end

   // galois form, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   task automatic take_bits(input logic bus_side, input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         if (bus_side) begin
            v[i]     = bus_seed[0];
            bus_seed = lfsr_step(bus_seed);
         end else begin
            v[i]      = stim_seed[0];
            stim_seed = lfsr_step(stim_seed);
         end
      end
   endtask

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input sg_data_t got_data, input logic got_last);
      sg_word_t exp;
      if (expected_q.size() == 0)
         abort_run("stream delivered a word when none was expected");
      exp = expected_q.pop_front();
      if (got_data !== exp.data || got_last !== exp.last)
         abort_run($sformatf("Mismatch at %0d ns: stream word %h last %b, expected %h last %b",
                             $time, got_data, got_last, exp.data, exp.last));
   endtask

   task automatic check_status(input logic exp_done, input logic exp_err);
      if (done_o !== exp_done || error_o !== exp_err)
         abort_run($sformatf("Mismatch at %0d ns: done %b error %b, expected done %b error %b",
                             $time, done_o, error_o, exp_done, exp_err));
   endtask

   task automatic store_word(input sg_waddr_t addr, input sg_data_t data);
      u_sg_wb_mem.mem[addr[11:0]] = data;      // all chains live below 4k words
   endtask

   // lays a chain out in memory and queues its words in chain order
   task automatic build_chain(input logic to_trap, output sg_waddr_t first);
      logic [63:0] r;
      int          n_desc;
      sg_waddr_t   desc_addr [4];
      sg_waddr_t   buf_addr;
      sg_waddr_t   next;
      sg_len_t     len;
      logic        last;
      sg_data_t    beat0;
      sg_word_t    exp;
      take_bits(1'b0, 2, r);
      n_desc = int'(r[1:0]) + 1;
      for (int d = 0; d < n_desc; d++) begin
         take_bits(1'b0, 3, r);
         desc_addr[d] = sg_waddr_t'(16 * (slot + d)) + sg_waddr_t'(r[2:0]);
      end
      for (int d = 0; d < n_desc; d++) begin
         take_bits(1'b0, 3, r);
         buf_addr = BUF_BASE + sg_waddr_t'(16 * (slot + d)) + sg_waddr_t'(r[2:0]);
         take_bits(1'b0, 3, r);
         len  = sg_len_t'(int'(r[2:0]) % 7);    // 0 to 6 words
         last = (d == n_desc - 1) && !to_trap;
         if (d == n_desc - 1)
            next = to_trap ? TRAP_WADDR : '0;
         else
            next = desc_addr[d + 1];
         beat0 = '0;
         beat0[31:0] = {buf_addr, 3'b000};
         beat0[32 + DESC_LEN_LSB +: $bits(sg_len_t)] = len;
         beat0[32 + DESC_LAST_BIT] = last;
         store_word(desc_addr[d], beat0);
         take_bits(1'b0, 32, r);               // low half of beat 1 is unused
         store_word(desc_addr[d] + 1'b1, {next, 3'b000, r[31:0]});
         for (int w = 0; w < int'(len); w++) begin
            take_bits(1'b0, 64, r);
            store_word(buf_addr + sg_waddr_t'(w), r);
            exp.data = r;
            exp.last = last && (w == int'(len) - 1);
            expected_q.push_back(exp);
         end
      end
      slot  = slot + n_desc;
      first = desc_addr[0];
   endtask

   task automatic send_cmd(input sg_waddr_t addr);
      int n;
      n = 0;
      do begin
         @(posedge wb_clk_i);
         #2;
         if (n == TIMEOUT)
            abort_run("timeout waiting for cmd_ready_o");
         n++;
      end while (!cmd_ready_o);
      cmd_valid_i = 1'b1;
      cmd_addr_i  = addr;
      @(posedge wb_clk_i);                     // taken here
      #2;
      cmd_valid_i = 1'b0;
      @(negedge wb_clk_i);
      check_status(1'b0, 1'b0);                // accept clears an old error
   endtask

   task automatic wait_finish(input logic expect_err);
      int n;
      n = 0;
      do begin
         @(negedge wb_clk_i);
         if (n == TIMEOUT)
            abort_run(expect_err ? "timeout waiting for error_o" : "timeout waiting for done_o");
         n++;
      end while (!done_o && !error_o);
      check_status(!expect_err, expect_err);
      @(negedge wb_clk_i);
      check_status(1'b0, expect_err);          // done one cycle, error sticky
      if (!cmd_ready_o)
         abort_run("walker did not return to idle after the chain ended");
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (expected_q.size() != 0) begin
         if (n == TIMEOUT)
            abort_run("timeout waiting for the stream to drain");
         @(posedge wb_clk_i);
         #2;
         n++;
      end
      repeat (8) @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      if (st_valid_o)
         abort_run("stream still offers a word after every expected word arrived");
   endtask

   // transfer happens at the next rising edge, values settled by now
   always @(negedge wb_clk_i) begin
      if (!wb_rst_i && st_valid_o && st_ready_i)
         check_word(st_data_o, st_last_o);
   end

   always @(posedge wb_clk_i) begin
      logic [63:0] r;
      #2;
      take_bits(1'b1, 4, r);
      st_ready_i = r[0] & r[1];                // sink ready about a quarter of cycles
      ack_delay  = r[3:2];
   end

   initial begin
      sg_waddr_t first;
      stim_seed   = 32'hf70f;
      bus_seed    = 32'hf70f;
      slot        = 0;
      wb_rst_i    = 1'b1;
      cmd_valid_i = 1'b0;
      cmd_addr_i  = '0;
      st_ready_i  = 1'b0;
      ack_delay   = 2'd0;
      repeat (10) @(posedge wb_clk_i);
      #2;
      wb_rst_i = 1'b0;
      @(negedge wb_clk_i);
      check_status(1'b0, 1'b0);
      if (!cmd_ready_o || wbm_cyc_o || wbm_stb_o || st_valid_o)
         abort_run("outputs not at their reset values after reset");
      for (int c = 0; c < N_CMD; c++) begin
         build_chain(c == ERR_CMD, first);
         send_cmd(first);
         wait_finish(c == ERR_CMD);
      end
      wait_drain();
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule
